/* build.f */
+incdir+hw
hw/debug_pkg.sv
hw/dbg_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/debug_unit.sv
hw/tiny_core.sv
hw/debug_top.sv
dv/tb_debug_top.sv

/* dv/tb_debug_top.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module tb_debug_top;

    localparam int RX_WAIT = 40 * `CLKS_PER_BIT;  // cycles allowed per wait

    localparam logic [3:0] ST_IDLE = 4'd0;
    localparam logic [3:0] OP_NOP  = 4'h0;
    localparam logic [3:0] OP_LI   = 4'h1;
    localparam logic [3:0] OP_ADD  = 4'h2;
    localparam logic [3:0] OP_SUB  = 4'h3;
    localparam logic [3:0] OP_LD   = 4'h4;
    localparam logic [3:0] OP_ST   = 4'h5;
    localparam logic [3:0] OP_HALT = 4'hf;

    localparam logic [7:0] CMD_LOAD = 8'h4c;
    localparam logic [7:0] CMD_RUN  = 8'h52;
    localparam logic [7:0] CMD_STEP = 8'h53;

    logic       i_clock;
    logic       i_rst_n;
    logic       i_uart_rx;
    logic       o_uart_tx;
    logic [3:0] o_state;

    logic [15:0] prog [`IM_DEPTH];
    logic [7:0]  dump [`DUMP_LEN];
    logic [7:0]  prev_dump [`DUMP_LEN];
    logic [7:0]  m_pc;                // reference model
    logic [7:0]  m_rb [`RB_DEPTH];
    logic [7:0]  m_dm [`DM_DEPTH];
    logic        m_halted;
    logic        quiet;               // no reply expected
    string       test_name;

    debug_top u_debug_top (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx),
        .o_state   (o_state)
    );

    initial begin
        i_clock = 1'b0;
        forever #4 i_clock = ~i_clock;
    end

    a_quiet_line: assert property (@(posedge i_clock) disable iff (!i_rst_n || !quiet)
        o_uart_tx && o_state == ST_IDLE)
        else begin
            $display("Test FAILED");
            $display("DUT left idle or transmitted while no reply was expected");
            $fatal(1);
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side uart
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic tick(input int n);
        repeat (n) @(posedge i_clock);
        #1;  // drive and sample point
    endtask

    task automatic abort_test(input string what);
        $display("Test FAILED");
        $display("test %s: %s", test_name, what);
        $fatal(1);
    endtask

    task automatic send_byte(input logic [7:0] b);
        i_uart_rx = 1'b0;
        tick(`CLKS_PER_BIT);
        for (int k = 0; k < 8; k++) begin
            i_uart_rx = b[k];  // lsb first
            tick(`CLKS_PER_BIT);
        end
        i_uart_rx = 1'b1;
        tick(`CLKS_PER_BIT);
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int t;
        t = 0;
        while (o_uart_tx !== 1'b0) begin
            tick(1);
            t++;
            if (t > RX_WAIT) abort_test("timeout waiting for a start bit from the DUT");
        end
        tick(`CLKS_PER_BIT / 2);  // mid start bit
        if (o_uart_tx !== 1'b0) abort_test("start bit from the DUT was too short");
        for (int k = 0; k < 8; k++) begin
            tick(`CLKS_PER_BIT);
            b[k] = o_uart_tx;
        end
        tick(`CLKS_PER_BIT);
        if (o_uart_tx !== 1'b1) abort_test("stop bit from the DUT missing");
    endtask

    task automatic recv_dump();
        for (int k = 0; k < `DUMP_LEN; k++) begin
            recv_byte(dump[k]);
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (o_state !== ST_IDLE) begin
            tick(1);
            t++;
            if (t > RX_WAIT) abort_test("timeout waiting for the debug FSM to return to idle");
        end
    endtask

    // dump can start before the stop bit ends
    task automatic run_command(input logic [7:0] cmd);
        wait_idle();
        fork
            send_byte(cmd);
            recv_dump();
        join
        wait_idle();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [15:0] imm_word(logic [3:0] op, logic [2:0] rd, logic [7:0] imm);
        return {op, rd, 1'b0, imm};
    endfunction

    function automatic logic [15:0] reg_word(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                             logic [2:0] rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    task automatic model_clear();
        m_pc     = '0;
        m_halted = 1'b0;
        for (int k = 0; k < `RB_DEPTH; k++) m_rb[k] = '0;
        for (int k = 0; k < `DM_DEPTH; k++) m_dm[k] = '0;
    endtask

    task automatic model_step();
        logic [15:0] w;
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [7:0]  imm;
        if (!m_halted) begin
            w   = prog[m_pc];
            op  = w[15:12];
            rd  = w[11:9];
            rs  = w[8:6];
            rt  = w[5:3];
            imm = w[7:0];
            case (op)
                OP_LI:   m_rb[rd] = imm;
                OP_ADD:  m_rb[rd] = m_rb[rs] + m_rb[rt];
                OP_SUB:  m_rb[rd] = m_rb[rs] - m_rb[rt];
                OP_LD:   m_rb[rd] = m_dm[imm[3:0]];
                OP_ST:   m_dm[imm[3:0]] = m_rb[rd];
                default: ;
            endcase
            if (op == OP_HALT) m_halted = 1'b1;
            else m_pc = (m_pc + 8'd1) % 8'(`IM_DEPTH);
        end
    endtask

    task automatic load_program(input int n);
        send_byte(CMD_LOAD);
        send_byte(8'(n));
        for (int k = 0; k < n; k++) begin
            send_byte(prog[k][15:8]);  // high byte first
            send_byte(prog[k][7:0]);
        end
        model_clear();
    endtask

    task automatic check_byte(input int idx, input logic [7:0] exp, input logic [7:0] act);
        a_dump_byte: assert (act === exp)
            else begin
                $display("** Error %s: dump byte %0d expected %02h actual %02h",
                         test_name, idx, exp, act);
                $display("Test FAILED");
                $fatal(1);
            end
    endtask

    task automatic check_dump();
        logic [7:0] exp;
        for (int k = 0; k < `DUMP_LEN; k++) begin
            if (k == 0) exp = m_pc;
            else if (k <= `RB_DEPTH) exp = m_rb[k - 1];
            else exp = m_dm[k - 1 - `RB_DEPTH];
            check_byte(k, exp, dump[k]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [7:0] st_addr;
        void'($urandom(32'h6641_d93e));
        i_rst_n   = 1'b0;
        i_uart_rx = 1'b1;
        quiet     = 1'b1;
        test_name = "reset";
        model_clear();
        for (int k = 0; k < `IM_DEPTH; k++) prog[k] = '0;
        repeat (3) @(posedge i_clock);
        #1 i_rst_n = 1'b1;
        tick(50);  // line idle, fsm idle
        quiet = 1'b0;

        test_name = "load_run";
        st_addr = 8'($urandom);
        prog[0] = imm_word(OP_LI, 3'd1, 8'($urandom));
        prog[1] = imm_word(OP_LI, 3'd2, 8'($urandom));
        prog[2] = reg_word(OP_ADD, 3'd3, 3'd1, 3'd2);
        prog[3] = imm_word(OP_LI, 3'd4, 8'($urandom));
        prog[4] = reg_word(OP_ADD, 3'd5, 3'd3, 3'd4);
        prog[5] = reg_word(OP_SUB, 3'd6, 3'd5, 3'd1);
        prog[6] = imm_word(OP_ST, 3'd6, st_addr);
        prog[7] = imm_word(OP_LD, 3'd7, {~st_addr[7:4], st_addr[3:0]}); // upper bits ignored
        prog[8] = imm_word(OP_HALT, 3'd0, 8'd0);
        load_program(9);
        for (int k = 0; k < 64 && !m_halted; k++) model_step();
        run_command(CMD_RUN);
        check_dump();
        check_byte(0, 8'd8, dump[0]);

        test_name = "step";
        load_program(9);
        for (int s = 0; s < 9; s++) begin
            model_step();
            run_command(CMD_STEP);
            check_dump();
            check_byte(0, (s < 8) ? 8'(s + 1) : 8'd8, dump[0]);
        end
        for (int k = 0; k < `DUMP_LEN; k++) prev_dump[k] = dump[k];

        test_name = "halt_hold";
        run_command(CMD_STEP);
        for (int k = 0; k < `DUMP_LEN; k++) check_byte(k, prev_dump[k], dump[k]);

        test_name = "reload";
        for (int k = 0; k < 4; k++) prog[k] = imm_word(OP_NOP, 3'd0, 8'd0);
        load_program(4);
        model_step();
        run_command(CMD_STEP);
        check_dump();

        test_name = "unknown_cmd";
        wait_idle();
        quiet = 1'b1;
        send_byte(8'h58);
        tick(RX_WAIT);
        quiet = 1'b0;

        $display("Test OK");
        $finish;
    end

endmodule

/* hw/dbg_if.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

interface dbg_if;

    // instruction memory load
    logic                            im_we;
    logic [$clog2(`IM_DEPTH)-1:0]    im_addr;
    logic [15:0]                     im_data;

    // run control
    logic                            exec_en;
    logic                            core_clr;
    logic                            halted;
    logic [7:0]                      pc;

    // debug reads
    logic [$clog2(`RB_DEPTH)-1:0]    rb_addr;
    logic [7:0]                      rb_data;
    logic [$clog2(`DM_DEPTH)-1:0]    dm_addr;
    logic [7:0]                      dm_data;

    modport debug (
        output im_we, im_addr, im_data, exec_en, core_clr, rb_addr, dm_addr,
        input  halted, pc, rb_data, dm_data
    );

    modport core (
        input  im_we, im_addr, im_data, exec_en, core_clr, rb_addr, dm_addr,
        output halted, pc, rb_data, dm_data
    );

endinterface

/* hw/debug_defs.svh */
`ifndef DEBUG_DEFS_SVH
`define DEBUG_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CLKS_PER_BIT 16 // clocks per uart bit

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define IM_DEPTH 32 // instruction words
`define DM_DEPTH 16 // data bytes
`define RB_DEPTH 8  // registers

// pc, then registers, then data memory
`define DUMP_LEN (1 + `RB_DEPTH + `DM_DEPTH)

`endif

/* hw/debug_pkg.sv */
package debug_pkg;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        LOAD_CNT  = 4'd1,
        LOAD_HI   = 4'd2,
        LOAD_LO   = 4'd3,
        RUN       = 4'd4,
        STEP      = 4'd5,
        DUMP      = 4'd6,
        SEND_WAIT = 4'd7
    } state_e;

    typedef enum logic [3:0] {
        NOP  = 4'h0,
        LI   = 4'h1,
        ADD  = 4'h2,
        SUB  = 4'h3,
        LD   = 4'h4,
        ST   = 4'h5,
        HALT = 4'hf
    } opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word, two decodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef union packed {
        struct packed {
            opcode_e    op;
            logic [2:0] rd;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] unused;
        } r;
        struct packed {
            opcode_e    op;
            logic [2:0] rd;
            logic       unused;
            logic [7:0] imm;
        } i;
    } instr_u;

endpackage

/* hw/debug_top.sv */
`timescale 1ns/1ns

module debug_top (
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  logic       i_uart_rx,
    output logic       o_uart_tx,
    output logic [3:0] o_state
);

    logic       rx_done;
    logic [7:0] rx_data;
    logic       tx_done;
    logic       tx_start;
    logic [7:0] tx_data;

    dbg_if core_bus ();

    uart_rx u_uart_rx (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_rx    (i_uart_rx),
        .o_data  (rx_data),
        .o_done  (rx_done)
    );

    uart_tx u_uart_tx (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_data  (tx_data),
        .i_start (tx_start),
        .o_tx    (o_uart_tx),
        .o_done  (tx_done)
    );

    debug_unit u_debug_unit (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .i_tx_done  (tx_done),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start),
        .o_state    (o_state),
        .core_bus   (core_bus.debug)
    );

    tiny_core u_tiny_core (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .core_bus (core_bus.core)
    );

endmodule

/* hw/debug_unit.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module debug_unit (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic [7:0]         i_rx_data,
    input  logic               i_rx_done,
    input  logic               i_tx_done,
    output logic [7:0]         o_tx_data,
    output logic               o_tx_start,
    output debug_pkg::state_e  o_state,
    dbg_if.debug               core_bus
);

    localparam int IW    = $clog2(`DUMP_LEN);
    localparam int RB_AW = $clog2(`RB_DEPTH);
    localparam int DM_AW = $clog2(`DM_DEPTH);

    localparam logic [IW-1:0] IDX_LAST = IW'(`DUMP_LEN - 1);
    localparam logic [IW-1:0] IDX_RB   = IW'(`RB_DEPTH);
    localparam logic [IW-1:0] IDX_DM   = IW'(1 + `RB_DEPTH);

    localparam logic [7:0] CMD_LOAD = 8'h4c;
    localparam logic [7:0] CMD_RUN  = 8'h52;
    localparam logic [7:0] CMD_STEP = 8'h53;

    debug_pkg::state_e state;
    debug_pkg::instr_u load_word;   // hi byte first
    logic [5:0]        words_left;
    logic [IW-1:0]     idx;         // dump byte index
    logic [IW-1:0]     rb_off;
    logic [IW-1:0]     dm_off;
    logic [7:0]        dump_byte;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command fsm
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state            <= debug_pkg::IDLE;
            core_bus.exec_en <= 1'b0;
            core_bus.im_we   <= 1'b0;
            core_bus.core_clr <= 1'b0;
            core_bus.im_addr <= '0;
            o_tx_start       <= 1'b0;
            words_left       <= '0;
            idx              <= '0;
        end else begin
            core_bus.im_we    <= 1'b0;
            core_bus.core_clr <= 1'b0;
            o_tx_start        <= 1'b0;
            if (core_bus.im_we) core_bus.im_addr <= core_bus.im_addr + 1'b1;
            case (state)
                debug_pkg::IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: state <= debug_pkg::LOAD_CNT;
                            CMD_RUN: begin
                                core_bus.exec_en <= 1'b1;
                                state            <= debug_pkg::RUN;
                            end
                            CMD_STEP: begin
                                core_bus.exec_en <= 1'b1; // single cycle
                                state            <= debug_pkg::STEP;
                            end
                            default: state <= debug_pkg::IDLE;
                        endcase
                    end
                end
                debug_pkg::LOAD_CNT: begin
                    if (i_rx_done) begin
                        if (i_rx_data != 8'd0 && i_rx_data <= 8'(`IM_DEPTH)) begin
                            words_left       <= i_rx_data[5:0];
                            core_bus.im_addr <= '0;
                            state            <= debug_pkg::LOAD_HI;
                        end else begin
                            state <= debug_pkg::IDLE; // bad count
                        end
                    end
                end
                debug_pkg::LOAD_HI: begin
                    if (i_rx_done) state <= debug_pkg::LOAD_LO;
                end
                debug_pkg::LOAD_LO: begin
                    if (i_rx_done) begin
                        core_bus.im_we <= 1'b1;
                        words_left     <= words_left - 1'b1;
                        if (words_left == 6'd1) begin
                            core_bus.core_clr <= 1'b1;
                            state             <= debug_pkg::IDLE;
                        end else begin
                            state <= debug_pkg::LOAD_HI;
                        end
                    end
                end
                debug_pkg::RUN: begin
                    if (core_bus.halted) begin
                        core_bus.exec_en <= 1'b0;
                        idx              <= '0;
                        state            <= debug_pkg::DUMP;
                    end
                end
                debug_pkg::STEP: begin
                    core_bus.exec_en <= 1'b0;
                    idx              <= '0;
                    state            <= debug_pkg::DUMP;
                end
                debug_pkg::DUMP: begin
                    o_tx_start <= 1'b1;
                    state      <= debug_pkg::SEND_WAIT;
                end
                debug_pkg::SEND_WAIT: begin
                    if (i_tx_done) begin
                        if (idx == IDX_LAST) begin
                            state <= debug_pkg::IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= debug_pkg::DUMP;
                        end
                    end
                end
                default: state <= debug_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == debug_pkg::LOAD_HI && i_rx_done) load_word[15:8] <= i_rx_data;
        if (state == debug_pkg::LOAD_LO && i_rx_done) load_word[7:0] <= i_rx_data;
        if (state == debug_pkg::DUMP) o_tx_data <= dump_byte;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // dump byte select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rb_off = idx - 1'b1;
    assign dm_off = idx - IDX_DM;

    always_comb begin
        if (idx == '0) dump_byte = core_bus.pc;
        else if (idx <= IDX_RB) dump_byte = core_bus.rb_data;
        else dump_byte = core_bus.dm_data;
    end

    assign core_bus.rb_addr = rb_off[RB_AW-1:0];
    assign core_bus.dm_addr = dm_off[DM_AW-1:0];
    assign core_bus.im_data = load_word;
    assign o_state          = state;

    a_no_exec_on_load: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        core_bus.im_we |-> !core_bus.exec_en);

endmodule

/* hw/tiny_core.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module tiny_core (
    input  logic i_clock,
    input  logic i_rst_n,
    dbg_if.core  core_bus
);

    localparam int IM_AW = $clog2(`IM_DEPTH);
    localparam int DM_AW = $clog2(`DM_DEPTH);

    logic [15:0]      imem [`IM_DEPTH];
    logic [7:0]       rbank [`RB_DEPTH];
    logic [7:0]       dmem [`DM_DEPTH];
    logic [IM_AW-1:0] pc_q;           // wraps within imem
    logic             halted_q;

    debug_pkg::instr_u instr;
    logic              exec_go;

    assign instr   = imem[pc_q];
    assign exec_go = core_bus.exec_en && !halted_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock) begin
        if (core_bus.im_we) imem[core_bus.im_addr] <= core_bus.im_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pc and halt
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
        end else if (core_bus.core_clr) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
        end else if (exec_go) begin
            if (instr.i.op == debug_pkg::HALT) halted_q <= 1'b1; // pc stays on halt
            else pc_q <= pc_q + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock) begin
        if (core_bus.core_clr) begin
            for (int k = 0; k < `RB_DEPTH; k++) begin
                rbank[k] <= '0;
            end
            for (int k = 0; k < `DM_DEPTH; k++) begin
                dmem[k] <= '0;
            end
        end else if (exec_go) begin
            case (instr.i.op)
                debug_pkg::LI: rbank[instr.i.rd] <= instr.i.imm;
                debug_pkg::ADD: begin
                    rbank[instr.r.rd] <= rbank[instr.r.rs] + rbank[instr.r.rt];
                end
                debug_pkg::SUB: begin
                    rbank[instr.r.rd] <= rbank[instr.r.rs] - rbank[instr.r.rt];
                end
                debug_pkg::LD: rbank[instr.i.rd] <= dmem[instr.i.imm[DM_AW-1:0]];
                debug_pkg::ST: dmem[instr.i.imm[DM_AW-1:0]] <= rbank[instr.i.rd];
                default: ; // nop, halt, undefined
            endcase
        end
    end

    // debug read side
    assign core_bus.rb_data = rbank[core_bus.rb_addr];
    assign core_bus.dm_data = dmem[core_bus.dm_addr];
    assign core_bus.pc      = {{(8 - IM_AW){1'b0}}, pc_q};
    assign core_bus.halted  = halted_q;

    a_pc_frozen: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        halted_q && !core_bus.core_clr |=> $stable(pc_q));

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module uart_rx (
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  logic       i_rx,
    output logic [7:0] o_data,
    output logic       o_done
);

    localparam int CW = $clog2(`CLKS_PER_BIT);
    localparam logic [CW-1:0] CNT_LAST = CW'(`CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] CNT_HALF = CW'(`CLKS_PER_BIT / 2 - 1);

    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    logic [1:0]    rx_meta;  // two flop sync
    logic [1:0]    st;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shreg;

    wire rx_s = rx_meta[1];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 2'b11;
            st      <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_done  <= 1'b0;
        end else begin
            rx_meta <= {rx_meta[0], i_rx};
            o_done  <= 1'b0;
            case (st)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) st <= RX_START; // falling edge
                end
                RX_START: begin
                    if (cnt == CNT_HALF) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        st      <= rx_s ? RX_IDLE : RX_DATA; // glitch check
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == CNT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) st <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == CNT_LAST) begin
                        cnt    <= '0;
                        o_done <= 1'b1;
                        st     <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (st == RX_DATA && cnt == CNT_LAST) shreg <= {rx_s, shreg[7:1]}; // lsb first
    end

    assign o_data = shreg;

    a_done_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_done |=> !o_done);

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module uart_tx (
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  logic [7:0] i_data,
    input  logic       i_start,
    output logic       o_tx,
    output logic       o_done
);

    localparam int CW = $clog2(`CLKS_PER_BIT);
    localparam logic [CW-1:0] CNT_LAST = CW'(`CLKS_PER_BIT - 1);

    logic          busy;
    logic [CW-1:0] cnt;
    logic [3:0]    bit_cnt;  // 0 start, 9 stop
    logic [8:0]    shreg;    // stop bit rides above the data

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            o_tx    <= 1'b1;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy) begin
                if (i_start) begin
                    busy    <= 1'b1;
                    cnt     <= '0;
                    bit_cnt <= '0;
                    o_tx    <= 1'b0; // start bit
                end
            end else if (cnt == CNT_LAST) begin
                cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy   <= 1'b0;
                    o_tx   <= 1'b1;
                    o_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    o_tx    <= shreg[0];
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (!busy && i_start) shreg <= {1'b1, i_data};
        else if (busy && cnt == CNT_LAST) shreg <= {1'b1, shreg[8:1]};
    end

    a_no_start_busy: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        busy |-> !i_start);

endmodule
